/* hdl/isaPkg.sv */
// Instruction set definitions for the 16-bit teaching core
// Opcode and function encodings, instruction field positions
// and register file geometry
package isaPkg;

  // Top five bits of every instruction
  typedef enum logic [4:0] {
    opHalt  = 5'b00000,
    opNop   = 5'b00001,
    opJ     = 5'b00100,
    opJal   = 5'b00110,
    opAddi  = 5'b01000,
    opSubi  = 5'b01001,
    opXori  = 5'b01010,
    opAndni = 5'b01011,
    opBeqz  = 5'b01100,
    opBnez  = 5'b01101,
    opSt    = 5'b10000,
    opLd    = 5'b10001,
    opSlbi  = 5'b10010,
    opLbi   = 5'b11000,
    opAlu   = 5'b11011
  } opcodeT;

  // R-type function field, bits 1:0
  typedef enum logic [1:0] {
    fnAdd  = 2'b00,
    fnSub  = 2'b01,
    fnXor  = 2'b10,
    fnAndn = 2'b11
  } aluFuncT;

  // Field positions
  localparam int opMsb     = 15;
  localparam int opLsb     = 11;
  localparam int rsMsb     = 10;
  localparam int rsLsb     = 8;
  localparam int rtMsb     = 7;
  localparam int rtLsb     = 5;
  localparam int rdRMsb    = 4;
  localparam int rdRLsb    = 2;
  localparam int rdIMsb    = 7;
  localparam int rdILsb    = 5;
  localparam int funcMsb   = 1;
  localparam int funcLsb   = 0;
  localparam int imm5Msb   = 4;
  localparam int imm8Msb   = 7;
  localparam int disp11Msb = 10;

  // Register file geometry
  localparam int regCount    = 8;
  localparam int regAddrBits = $clog2(regCount);
  localparam logic [regAddrBits-1:0] linkReg = 3'd7;

endpackage

/* hdl/datapathPkg.sv */
// Datapath definitions for the 16-bit core
// ALU operations, immediate formats, writeback sources
// and data memory geometry
package datapathPkg;

  localparam int wordWidth = 16;

  // Data RAM size in words, byte bit dropped from the address
  localparam int memWords    = 256;
  localparam int memAddrBits = $clog2(memWords);

  // Subtract is add with invA and cin, ANDN is and with invB
  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluXor   = 3'd1,
    aluAnd   = 3'd2,
    aluPassB = 3'd3,
    aluSlbi  = 3'd4
  } aluOpT;

  // Immediate width and extension
  typedef enum logic [2:0] {
    immSext5  = 3'd0,
    immZext5  = 3'd1,
    immSext8  = 3'd2,
    immZext8  = 3'd3,
    immSext11 = 3'd4
  } immSelT;

  // Register writeback source
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,
    wbMem  = 2'd1,
    wbLink = 2'd2
  } wbSrcT;

endpackage

/* hdl/controlUnit.sv */
// Control unit
// Decodes opcode and function field into datapath control
// levels, picks the destination register and flags
// opcodes outside the supported subset
`timescale 1ns/1ps

module controlUnit (
  input  logic [datapathPkg::wordWidth-1:0] instr,
  output logic                              regWrite,
  output logic                              memWrite,
  output logic                              invA,
  output logic                              invB,
  output logic                              cin,
  output logic                              useImm,
  output logic                              branchZero,
  output logic                              branchNonZero,
  output logic                              jump,
  output logic                              halt,
  output logic                              illegal,
  output datapathPkg::aluOpT                aluOp,
  output datapathPkg::immSelT               immSel,
  output datapathPkg::wbSrcT                wbSrc,
  output logic [isaPkg::regAddrBits-1:0]    destReg
);

  isaPkg::opcodeT                 opcode;
  isaPkg::aluFuncT                func;
  logic [isaPkg::regAddrBits-1:0] rsField;
  logic [isaPkg::regAddrBits-1:0] rdRField;
  logic [isaPkg::regAddrBits-1:0] rdIField;

  assign opcode   = isaPkg::opcodeT'(instr[isaPkg::opMsb:isaPkg::opLsb]);
  assign func     = isaPkg::aluFuncT'(instr[isaPkg::funcMsb:isaPkg::funcLsb]);
  assign rsField  = instr[isaPkg::rsMsb:isaPkg::rsLsb];
  assign rdRField = instr[isaPkg::rdRMsb:isaPkg::rdRLsb];
  assign rdIField = instr[isaPkg::rdIMsb:isaPkg::rdILsb];

  always_comb begin
    // Quiet defaults, an I-type add with nothing written
    regWrite      = 1'b0;
    memWrite      = 1'b0;
    invA          = 1'b0;
    invB          = 1'b0;
    cin           = 1'b0;
    useImm        = 1'b0;
    branchZero    = 1'b0;
    branchNonZero = 1'b0;
    jump          = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    aluOp         = datapathPkg::aluAdd;
    immSel        = datapathPkg::immSext5;
    wbSrc         = datapathPkg::wbAlu;
    destReg       = rdIField;

    case (opcode)
      isaPkg::opHalt: halt = 1'b1;
      isaPkg::opNop: ;
      isaPkg::opAddi: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
      end
      // Immediate minus rs
      isaPkg::opSubi: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        invA     = 1'b1;
        cin      = 1'b1;
      end
      isaPkg::opXori: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        immSel   = datapathPkg::immZext5;
        aluOp    = datapathPkg::aluXor;
      end
      isaPkg::opAndni: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        immSel   = datapathPkg::immZext5;
        aluOp    = datapathPkg::aluAnd;
        invB     = 1'b1;
      end
      // Address is rs plus offset, store data read through rt
      isaPkg::opSt: begin
        memWrite = 1'b1;
        useImm   = 1'b1;
      end
      isaPkg::opLd: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        wbSrc    = datapathPkg::wbMem;
      end
      // Byte loads write back into rs
      isaPkg::opLbi: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        immSel   = datapathPkg::immSext8;
        aluOp    = datapathPkg::aluPassB;
        destReg  = rsField;
      end
      isaPkg::opSlbi: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        immSel   = datapathPkg::immZext8;
        aluOp    = datapathPkg::aluSlbi;
        destReg  = rsField;
      end
      isaPkg::opBeqz: begin
        branchZero = 1'b1;
        immSel     = datapathPkg::immSext8;
      end
      isaPkg::opBnez: begin
        branchNonZero = 1'b1;
        immSel        = datapathPkg::immSext8;
      end
      isaPkg::opJ: begin
        jump   = 1'b1;
        immSel = datapathPkg::immSext11;
      end
      isaPkg::opJal: begin
        jump     = 1'b1;
        regWrite = 1'b1;
        immSel   = datapathPkg::immSext11;
        wbSrc    = datapathPkg::wbLink;
        destReg  = isaPkg::linkReg;
      end
      isaPkg::opAlu: begin
        regWrite = 1'b1;
        destReg  = rdRField;
        case (func)
          // rt minus rs
          isaPkg::fnSub: begin
            invA = 1'b1;
            cin  = 1'b1;
          end
          isaPkg::fnXor:  aluOp = datapathPkg::aluXor;
          isaPkg::fnAndn: begin
            aluOp = datapathPkg::aluAnd;
            invB  = 1'b1;
          end
          default: aluOp = datapathPkg::aluAdd;
        endcase
      end
      // Unsupported opcode, no state is touched
      default: illegal = 1'b1;
    endcase
  end

endmodule

/* hdl/fetchUnit.sv */
// Fetch unit
// Program counter with PC+2 increment, redirect to a branch
// or jump target, and a sticky halted flag that freezes it
`timescale 1ns/1ps

module fetchUnit (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              halt,
  input  logic                              redirect,
  input  logic [datapathPkg::wordWidth-1:0] target,
  output logic [datapathPkg::wordWidth-1:0] pc,
  output logic [datapathPkg::wordWidth-1:0] pcPlus2,
  output logic                              halted
);

  logic [datapathPkg::wordWidth-1:0] pcNext;

  // Byte addressed, one 16-bit instruction per step
  assign pcPlus2 = pc + datapathPkg::wordWidth'(2);

  always_comb begin
    if (halt || halted) begin
      pcNext = pc;
    end else if (redirect) begin
      pcNext = target;
    end else begin
      pcNext = pcPlus2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      pc <= pcNext;
      // Stays set until the next reset
      if (halt) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

/* hdl/registerFile.sv */
// Register file
// Eight 16-bit registers, two asynchronous read ports and
// one write port committed at the clock edge
`timescale 1ns/1ps

module registerFile (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              writeEn,
  input  logic [isaPkg::regAddrBits-1:0]    writeReg,
  input  logic [isaPkg::regAddrBits-1:0]    readRegA,
  input  logic [isaPkg::regAddrBits-1:0]    readRegB,
  input  logic [datapathPkg::wordWidth-1:0] writeData,
  output logic [datapathPkg::wordWidth-1:0] readA,
  output logic [datapathPkg::wordWidth-1:0] readB
);

  logic [datapathPkg::wordWidth-1:0] regs [isaPkg::regCount];

  // Reads see the value before this cycle's write
  assign readA = regs[readRegA];
  assign readB = regs[readRegB];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < isaPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeReg] <= writeData;
    end
  end

endmodule

/* hdl/executeUnit.sv */
// Execute unit
// Immediate extension, ALU with operand inversion and carry in,
// branch condition on rs and the PC relative target
`timescale 1ns/1ps

module executeUnit (
  input  logic [datapathPkg::wordWidth-1:0] instr,
  input  logic [datapathPkg::wordWidth-1:0] a,
  input  logic [datapathPkg::wordWidth-1:0] b,
  input  logic [datapathPkg::wordWidth-1:0] pcPlus2,
  input  datapathPkg::aluOpT                aluOp,
  input  datapathPkg::immSelT               immSel,
  input  logic                              invA,
  input  logic                              invB,
  input  logic                              cin,
  input  logic                              useImm,
  input  logic                              branchZero,
  input  logic                              branchNonZero,
  output logic [datapathPkg::wordWidth-1:0] aluResult,
  output logic [datapathPkg::wordWidth-1:0] branchTarget,
  output logic                              takeBranch
);

  localparam int w = datapathPkg::wordWidth;

  logic [w-1:0] imm;
  logic [w-1:0] opA;
  logic [w-1:0] opB;
  logic         rsZero;

  // Immediate formats
  always_comb begin
    case (immSel)
      datapathPkg::immZext5: begin
        imm = {{(w-isaPkg::imm5Msb-1){1'b0}}, instr[isaPkg::imm5Msb:0]};
      end
      datapathPkg::immSext8: begin
        imm = {{(w-isaPkg::imm8Msb-1){instr[isaPkg::imm8Msb]}},
               instr[isaPkg::imm8Msb:0]};
      end
      datapathPkg::immZext8: begin
        imm = {{(w-isaPkg::imm8Msb-1){1'b0}}, instr[isaPkg::imm8Msb:0]};
      end
      datapathPkg::immSext11: begin
        imm = {{(w-isaPkg::disp11Msb-1){instr[isaPkg::disp11Msb]}},
               instr[isaPkg::disp11Msb:0]};
      end
      default: begin
        imm = {{(w-isaPkg::imm5Msb-1){instr[isaPkg::imm5Msb]}},
               instr[isaPkg::imm5Msb:0]};
      end
    endcase
  end

  // Operand conditioning
  assign opA = invA ? ~a : a;
  assign opB = invB ? ~(useImm ? imm : b) : (useImm ? imm : b);

  always_comb begin
    case (aluOp)
      datapathPkg::aluXor:   aluResult = opA ^ opB;
      datapathPkg::aluAnd:   aluResult = opA & opB;
      datapathPkg::aluPassB: aluResult = opB;
      // Low byte of rs moves up, immediate fills the bottom
      datapathPkg::aluSlbi:  aluResult = {opA[w/2-1:0], {(w/2){1'b0}}} | opB;
      default:               aluResult = opA + opB + w'(cin);
    endcase
  end

  // Branches test rs against zero
  assign rsZero       = (a == '0);
  assign takeBranch   = (rsZero && branchZero) || (!rsZero && branchNonZero);
  assign branchTarget = pcPlus2 + imm;

endmodule

/* hdl/dataMemory.sv */
// Data memory
// Word organized RAM, combinational read and write at the
// rising clock edge, byte bit of the address ignored
`timescale 1ns/1ps

module dataMemory (
  input  logic                              clk,
  input  logic                              writeEn,
  input  logic [datapathPkg::wordWidth-1:0] address,
  input  logic [datapathPkg::wordWidth-1:0] writeData,
  output logic [datapathPkg::wordWidth-1:0] readData
);

  logic [datapathPkg::wordWidth-1:0] mem [datapathPkg::memWords];
  logic [datapathPkg::memAddrBits-1:0] wordAddr;

  // Word index, bit 0 selects a byte and is dropped
  assign wordAddr = address[datapathPkg::memAddrBits:1];

  assign readData = mem[wordAddr];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[wordAddr] <= writeData;
    end
  end

endmodule

/* hdl/proc.sv */
// Single-cycle processor top level
// Control unit, fetch, register file, execute and data memory
// with the writeback mux; the register write port is exported
// for observation
`timescale 1ns/1ps

module proc (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [datapathPkg::wordWidth-1:0] instr,
  output logic [datapathPkg::wordWidth-1:0] pc,
  output logic                              wbEn,
  output logic [isaPkg::regAddrBits-1:0]    wbReg,
  output logic [datapathPkg::wordWidth-1:0] wbData,
  output logic                              halted,
  output logic                              err
);

  logic                              regWrite;
  logic                              memWrite;
  logic                              invA;
  logic                              invB;
  logic                              cin;
  logic                              useImm;
  logic                              branchZero;
  logic                              branchNonZero;
  logic                              jump;
  logic                              halt;
  logic                              illegal;
  datapathPkg::aluOpT                aluOp;
  datapathPkg::immSelT               immSel;
  datapathPkg::wbSrcT                wbSrc;
  logic [isaPkg::regAddrBits-1:0]    destReg;
  logic [datapathPkg::wordWidth-1:0] pcPlus2;
  logic [datapathPkg::wordWidth-1:0] readA;
  logic [datapathPkg::wordWidth-1:0] readB;
  logic [datapathPkg::wordWidth-1:0] aluResult;
  logic [datapathPkg::wordWidth-1:0] branchTarget;
  logic [datapathPkg::wordWidth-1:0] readData;
  logic                              takeBranch;
  logic                              redirect;
  logic                              memWriteEn;

  controlUnit control (
    .instr(instr), .regWrite(regWrite), .memWrite(memWrite),
    .invA(invA), .invB(invB), .cin(cin), .useImm(useImm),
    .branchZero(branchZero), .branchNonZero(branchNonZero),
    .jump(jump), .halt(halt), .illegal(illegal), .aluOp(aluOp),
    .immSel(immSel), .wbSrc(wbSrc), .destReg(destReg)
  );

  fetchUnit fetch (
    .clk(clk), .rstN(rstN), .halt(halt), .redirect(redirect),
    .target(branchTarget), .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
  );

  // Port A reads rs, port B reads rt which doubles as ST data
  registerFile regFile (
    .clk(clk), .rstN(rstN), .writeEn(wbEn), .writeReg(wbReg),
    .readRegA(instr[isaPkg::rsMsb:isaPkg::rsLsb]),
    .readRegB(instr[isaPkg::rtMsb:isaPkg::rtLsb]),
    .writeData(wbData), .readA(readA), .readB(readB)
  );

  executeUnit execute (
    .instr(instr), .a(readA), .b(readB), .pcPlus2(pcPlus2),
    .aluOp(aluOp), .immSel(immSel), .invA(invA), .invB(invB),
    .cin(cin), .useImm(useImm), .branchZero(branchZero),
    .branchNonZero(branchNonZero), .aluResult(aluResult),
    .branchTarget(branchTarget), .takeBranch(takeBranch)
  );

  dataMemory dataMem (
    .clk(clk), .writeEn(memWriteEn), .address(aluResult),
    .writeData(readB), .readData(readData)
  );

  assign redirect = takeBranch || jump;

  // No state changes once halted or while in reset
  assign wbEn       = regWrite && !halted && rstN;
  assign memWriteEn = memWrite && !halted && rstN;
  assign wbReg      = destReg;

  always_comb begin
    case (wbSrc)
      datapathPkg::wbMem:  wbData = readData;
      datapathPkg::wbLink: wbData = pcPlus2;
      default:             wbData = aluResult;
    endcase
  end

  // Only the decoder can flag an error in this subset
  assign err = illegal;

endmodule

/* dv/procTb.sv */
// Testbench for the single-cycle 16-bit core
// Walks a hand-written instruction table through reset, arithmetic,
// memory, control flow, illegal opcode and halt, plus a random
// immediate ALU phase checked against a register model, and ends
// with a reset out of the halted state
`timescale 1ns/1ps

module procTb;

  localparam int tableLen  = 33;
  // First entry of the halt tail which runs after the random phase
  localparam int haltIdx   = 28;
  localparam int randCount = 32;
  localparam int timeoutNs = (16 + tableLen + randCount + 20) * 40;
  // Random phase starts right after the NOP at 0x44
  localparam logic [15:0] randStartPc = 16'h0046;
  localparam logic [15:0] haltPc      = 16'(16'h0046 + 2 * randCount);

  logic                              clk;
  logic                              rstN;
  logic [datapathPkg::wordWidth-1:0] instr;
  logic [datapathPkg::wordWidth-1:0] pc;
  logic                              wbEn;
  logic [isaPkg::regAddrBits-1:0]    wbReg;
  logic [datapathPkg::wordWidth-1:0] wbData;
  logic                              halted;
  logic                              err;

  // Stimulus and expected responses
  logic [datapathPkg::wordWidth-1:0] tabInstr [tableLen];
  logic [datapathPkg::wordWidth-1:0] tabPc    [tableLen];
  logic                              tabEn    [tableLen];
  logic [isaPkg::regAddrBits-1:0]    tabReg   [tableLen];
  logic [datapathPkg::wordWidth-1:0] tabData  [tableLen];
  logic                              tabErr   [tableLen];
  int                                fillIdx;

  // Register contents predicted from the ISA rules
  logic [datapathPkg::wordWidth-1:0] model [isaPkg::regCount];
  logic [31:0]                       lfsrState;

  proc UUT (
    .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .wbEn(wbEn),
    .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
  );

  always #20 clk = ~clk;

  task automatic failAndStop();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic checkWord(input string name, input logic [datapathPkg::wordWidth-1:0] actual,
                           input logic [datapathPkg::wordWidth-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      failAndStop();
    end
  endtask

  task automatic checkReg(input string name, input logic [isaPkg::regAddrBits-1:0] actual,
                          input logic [isaPkg::regAddrBits-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      failAndStop();
    end
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      failAndStop();
    end
  endtask

  // Instruction encoders
  function automatic logic [15:0] iType(isaPkg::opcodeT op, logic [2:0] rs, logic [2:0] rd,
                                        logic [4:0] imm);
    return {op, rs, rd, imm};
  endfunction

  function automatic logic [15:0] bType(isaPkg::opcodeT op, logic [2:0] rs, logic [7:0] imm);
    return {op, rs, imm};
  endfunction

  function automatic logic [15:0] jType(isaPkg::opcodeT op, logic [10:0] disp);
    return {op, disp};
  endfunction

  function automatic logic [15:0] rType(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                        isaPkg::aluFuncT fn);
    return {isaPkg::opAlu, rs, rt, rd, fn};
  endfunction

  // Galois LFSR stepped once per bit
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic logic [7:0] randField(input int width);
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      value[i] = nextBit();
    end
    return value;
  endfunction

  task automatic addEntry(input logic [15:0] ins, input logic [15:0] expPc, input logic en,
                          input logic [2:0] reg3, input logic [15:0] data, input logic errExp);
    tabInstr[fillIdx] = ins;
    tabPc[fillIdx]    = expPc;
    tabEn[fillIdx]    = en;
    tabReg[fillIdx]   = reg3;
    tabData[fillIdx]  = data;
    tabErr[fillIdx]   = errExp;
    fillIdx++;
  endtask

  task automatic buildTable();
    fillIdx = 0;
    // Registers read back as zero after reset
    addEntry(iType(isaPkg::opAddi, 3'd0, 3'd1, 5'd0), 16'h0000, 1'b1, 3'd1, 16'h0000, 1'b0);
    addEntry(iType(isaPkg::opAddi, 3'd7, 3'd2, 5'd0), 16'h0002, 1'b1, 3'd2, 16'h0000, 1'b0);
    addEntry(iType(isaPkg::opAddi, 3'd5, 3'd3, 5'd0), 16'h0004, 1'b1, 3'd3, 16'h0000, 1'b0);
    // Byte loads build r1 = 0x853C and r2 = 0x1234
    addEntry(bType(isaPkg::opLbi, 3'd1, 8'h85), 16'h0006, 1'b1, 3'd1, 16'hff85, 1'b0);
    addEntry(bType(isaPkg::opSlbi, 3'd1, 8'h3c), 16'h0008, 1'b1, 3'd1, 16'h853c, 1'b0);
    addEntry(bType(isaPkg::opLbi, 3'd2, 8'h12), 16'h000a, 1'b1, 3'd2, 16'h0012, 1'b0);
    addEntry(bType(isaPkg::opSlbi, 3'd2, 8'h34), 16'h000c, 1'b1, 3'd2, 16'h1234, 1'b0);
    // Immediate forms with ADDI of -1 and SUBI computing 5 - r2
    addEntry(iType(isaPkg::opAddi, 3'd2, 3'd3, 5'h1f), 16'h000e, 1'b1, 3'd3, 16'h1233, 1'b0);
    addEntry(iType(isaPkg::opSubi, 3'd2, 3'd4, 5'h05), 16'h0010, 1'b1, 3'd4, 16'hedd1, 1'b0);
    addEntry(iType(isaPkg::opXori, 3'd1, 3'd5, 5'h1f), 16'h0012, 1'b1, 3'd5, 16'h8523, 1'b0);
    addEntry(iType(isaPkg::opAndni, 3'd1, 3'd6, 5'h0c), 16'h0014, 1'b1, 3'd6, 16'h8530, 1'b0);
    // R-type forms where SUB is rt minus rs
    addEntry(rType(3'd1, 3'd2, 3'd7, isaPkg::fnAdd), 16'h0016, 1'b1, 3'd7, 16'h9770, 1'b0);
    addEntry(rType(3'd2, 3'd1, 3'd7, isaPkg::fnSub), 16'h0018, 1'b1, 3'd7, 16'h7308, 1'b0);
    addEntry(rType(3'd1, 3'd2, 3'd3, isaPkg::fnXor), 16'h001a, 1'b1, 3'd3, 16'h9708, 1'b0);
    addEntry(rType(3'd1, 3'd2, 3'd4, isaPkg::fnAndn), 16'h001c, 1'b1, 3'd4, 16'h8508, 1'b0);
    // Stores at r2+2 and r2-2 followed by loads from both
    addEntry(iType(isaPkg::opSt, 3'd2, 3'd1, 5'h02), 16'h001e, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(iType(isaPkg::opSt, 3'd2, 3'd3, 5'h1e), 16'h0020, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(iType(isaPkg::opLd, 3'd2, 3'd5, 5'h02), 16'h0022, 1'b1, 3'd5, 16'h853c, 1'b0);
    addEntry(iType(isaPkg::opLd, 3'd2, 3'd6, 5'h1e), 16'h0024, 1'b1, 3'd6, 16'h9708, 1'b0);
    // Taken and not taken branches on r0 = 0 and r1 != 0
    addEntry(bType(isaPkg::opBeqz, 3'd0, 8'h06), 16'h0026, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(bType(isaPkg::opBeqz, 3'd1, 8'h20), 16'h002e, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(bType(isaPkg::opBnez, 3'd1, 8'hf8), 16'h0030, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(bType(isaPkg::opBnez, 3'd0, 8'h40), 16'h002a, 1'b0, 3'd0, 16'h0000, 1'b0);
    // Jump forward and JAL backward with the link in r7
    addEntry(jType(isaPkg::opJ, 11'h020), 16'h002c, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(jType(isaPkg::opJal, 11'h7f0), 16'h004e, 1'b1, 3'd7, 16'h0050, 1'b0);
    addEntry(iType(isaPkg::opAddi, 3'd7, 3'd1, 5'd0), 16'h0040, 1'b1, 3'd1, 16'h0050, 1'b0);
    // Unused opcode 11111 still moves the PC on
    addEntry(16'hf800, 16'h0042, 1'b0, 3'd0, 16'h0000, 1'b1);
    addEntry(jType(isaPkg::opNop, 11'h000), 16'h0044, 1'b0, 3'd0, 16'h0000, 1'b0);
    // Halt tail with the PC frozen and nothing written
    addEntry(jType(isaPkg::opHalt, 11'h000), haltPc, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(iType(isaPkg::opAddi, 3'd1, 3'd2, 5'h03), haltPc, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(bType(isaPkg::opLbi, 3'd3, 8'h7f), haltPc, 1'b0, 3'd0, 16'h0000, 1'b0);
    addEntry(jType(isaPkg::opJal, 11'h010), haltPc, 1'b0, 3'd0, 16'h0000, 1'b0);
    // err is not masked by halted
    addEntry(16'hf800, haltPc, 1'b0, 3'd0, 16'h0000, 1'b1);
  endtask

  // Called 2 ns after a rising edge and returns at the same point of the next cycle
  task automatic applyStep(input logic [15:0] ins, input logic [15:0] expPc, input logic expEn,
                           input logic [2:0] expReg, input logic [15:0] expData,
                           input logic expErr, input logic expHalted);
    instr = ins;
    #16;
    checkWord("pc", pc, expPc);
    checkBit("wbEn", wbEn, expEn);
    if (expEn) begin
      checkReg("wbReg", wbReg, expReg);
      checkWord("wbData", wbData, expData);
    end
    checkBit("err", err, expErr);
    checkBit("halted", halted, expHalted);
    @(posedge clk);
    #2;
  endtask

  task automatic runTable(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      applyStep(tabInstr[i], tabPc[i], tabEn[i], tabReg[i], tabData[i], tabErr[i],
                i > haltIdx);
      if (tabEn[i]) begin
        model[tabReg[i]] = tabData[i];
      end
    end
  endtask

  // ADDI, XORI and ANDNI with random registers and immediates
  task automatic runRandom();
    logic [7:0]                        bits;
    logic [2:0]                        rs;
    logic [2:0]                        rd;
    logic [4:0]                        imm;
    logic [1:0]                        sel;
    logic [datapathPkg::wordWidth-1:0] expected;
    logic [datapathPkg::wordWidth-1:0] stepPc;
    isaPkg::opcodeT                    op;
    stepPc = randStartPc;
    for (int n = 0; n < randCount; n++) begin
      bits = randField(2);
      sel = bits[1:0];
      bits = randField(3);
      rs = bits[2:0];
      bits = randField(3);
      rd = bits[2:0];
      bits = randField(5);
      imm = bits[4:0];
      case (sel)
        2'd1: begin
          op = isaPkg::opXori;
          expected = model[rs] ^ {11'b0, imm};
        end
        2'd2: begin
          op = isaPkg::opAndni;
          expected = model[rs] & ~{11'b0, imm};
        end
        default: begin
          op = isaPkg::opAddi;
          expected = model[rs] + {{11{imm[4]}}, imm};
        end
      endcase
      applyStep(iType(op, rs, rd, imm), stepPc, 1'b1, rd, expected, 1'b0, 1'b0);
      model[rd] = expected;
      stepPc = stepPc + 16'd2;
    end
  endtask

  // Reset out of the halted state, then every register reads back zero
  task automatic resetFromHalt();
    rstN = 1'b0;
    @(posedge clk);
    #16;
    checkWord("pc", pc, 16'h0000);
    checkBit("wbEn", wbEn, 1'b0);
    checkBit("halted", halted, 1'b0);
    @(posedge clk);
    #2;
    rstN = 1'b1;
    for (int r = 0; r < isaPkg::regCount; r++) begin
      applyStep(iType(isaPkg::opAddi, 3'(r), 3'(r), 5'd0), 16'(2 * r), 1'b1, 3'(r),
                16'h0000, 1'b0, 1'b0);
    end
  endtask

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Timeout: the tests did not finish in time");
    failAndStop();
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    // During reset wbEn must stay low for a writing instruction
    instr = iType(isaPkg::opAddi, 3'd0, 3'd1, 5'd5);
    lfsrState = 32'hf9b27561;
    for (int r = 0; r < isaPkg::regCount; r++) begin
      model[r] = '0;
    end
    buildTable();
    repeat (15) @(posedge clk);
    #18;
    checkWord("pc", pc, 16'h0000);
    checkBit("wbEn", wbEn, 1'b0);
    checkBit("halted", halted, 1'b0);
    @(posedge clk);
    #2;
    rstN = 1'b1;
    runTable(0, haltIdx - 1);
    runRandom();
    runTable(haltIdx, tableLen - 1);
    resetFromHalt();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* sim.f */
hdl/isaPkg.sv
hdl/datapathPkg.sv
hdl/controlUnit.sv
hdl/fetchUnit.sv
hdl/registerFile.sv
hdl/executeUnit.sv
hdl/dataMemory.sv
hdl/proc.sv
dv/procTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module procTb -f sim.f

# The testbench stops with a nonzero status on failure, the search decides
output=$(./obj_dir/VprocTb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi
